// ==== design/tlu_consts.svh ====
`ifndef TLU_CONSTS_SVH
`define TLU_CONSTS_SVH

// trigger clock cycles per TLU clock period
`define TLU_DIVISOR 8

// TLU clock periods per trigger, the first one carries no data
`define TLU_CLOCK_PERIODS 17

// valid trigger number bits
`define TLU_NUMBER_BITS (`TLU_CLOCK_PERIODS - 1)

// data word, timestamp and trigger counter
`define TLU_WORD_BITS 32

// low timeout setting
`define TLU_TIMEOUT_BITS 8

`endif

// ==== design/tlu_controller_top.sv ====
`timescale 1ns/1ps
`include "tlu_consts.svh"

module tlu_controller_top
(
    input  logic                         trigger_clk,
    input  logic                         reset,
    input  logic                         trigger,
    input  logic                         trigger_veto,
    input  logic                         trigger_enable,
    input  logic                         trigger_acknowledge,
    input  logic                         fifo_acknowledge,
    input  logic                         trigger_counter_set,
    input  tlu_pkg::trigger_word_t       trigger_counter_set_value,
    input  tlu_pkg::trigger_mode_e       trigger_mode,
    input  tlu_pkg::data_format_e        conf_data_format,
    input  logic [`TLU_TIMEOUT_BITS-1:0] low_timeout,
    input  logic                         msb_first,
    input  logic                         tlu_reset_flag,
    output tlu_pkg::trigger_word_t       trigger_data,
    output logic                         trigger_data_write,
    output logic                         trigger_accepted_flag,
    output logic                         fifo_preempt_req,
    output logic                         tlu_busy,
    output logic                         tlu_clock,
    output logic                         low_timeout_error_flag,
    output tlu_pkg::trigger_word_t       timestamp
);

    logic                 tlu_clock_enable;   // FSM in clock-out phase
    logic                 number_done;
    tlu_pkg::tlu_number_t tlu_number;

    tlu_handshake_fsm u_tlu_handshake_fsm
    (
        .trigger_clk            (trigger_clk),
        .reset                  (reset),
        .trigger                (trigger),
        .trigger_veto           (trigger_veto),
        .trigger_enable         (trigger_enable),
        .trigger_mode           (trigger_mode),
        .low_timeout            (low_timeout),
        .trigger_acknowledge    (trigger_acknowledge),
        .fifo_acknowledge       (fifo_acknowledge),
        .number_done            (number_done),
        .trigger_accepted_flag  (trigger_accepted_flag),
        .trigger_data_write     (trigger_data_write),
        .fifo_preempt_req       (fifo_preempt_req),
        .tlu_busy               (tlu_busy),
        .tlu_clock_enable       (tlu_clock_enable),
        .low_timeout_error_flag (low_timeout_error_flag)
    );

    tlu_number_deserializer u_tlu_number_deserializer
    (
        .trigger_clk      (trigger_clk),
        .reset            (reset),
        .tlu_clock_enable (tlu_clock_enable),
        .trigger          (trigger),
        .msb_first        (msb_first),
        .tlu_clock        (tlu_clock),
        .number_done      (number_done),
        .tlu_number       (tlu_number)
    );

    tlu_event_stamper u_tlu_event_stamper
    (
        .trigger_clk               (trigger_clk),
        .reset                     (reset),
        .tlu_reset_flag            (tlu_reset_flag),
        .trigger_accepted_flag     (trigger_accepted_flag),
        .trigger_counter_set       (trigger_counter_set),
        .trigger_counter_set_value (trigger_counter_set_value),
        .trigger_mode              (trigger_mode),
        .conf_data_format          (conf_data_format),
        .tlu_number                (tlu_number),
        .timestamp                 (timestamp),
        .trigger_data              (trigger_data)
    );

endmodule

// ==== design/tlu_event_stamper.sv ====
`timescale 1ns/1ps
`include "tlu_consts.svh"

module tlu_event_stamper
(
    input  logic                   trigger_clk,
    input  logic                   reset,
    input  logic                   tlu_reset_flag,
    input  logic                   trigger_accepted_flag,
    input  logic                   trigger_counter_set,
    input  tlu_pkg::trigger_word_t trigger_counter_set_value,
    input  tlu_pkg::trigger_mode_e trigger_mode,
    input  tlu_pkg::data_format_e  conf_data_format,
    input  tlu_pkg::tlu_number_t   tlu_number,
    output tlu_pkg::trigger_word_t timestamp,
    output tlu_pkg::trigger_word_t trigger_data
);

    localparam int FIELD_W = `TLU_WORD_BITS - 1;                      // below the marker bit
    localparam int TS_W    = `TLU_WORD_BITS - 1 - `TLU_NUMBER_BITS;   // timestamp part of combined

    tlu_pkg::trigger_word_t trigger_counter;
    tlu_pkg::trigger_word_t timestamp_data;
    tlu_pkg::trigger_word_t counter_data;
    logic [FIELD_W-1:0]     number_field;

    // free running, cleared by the TLU
    always_ff @(posedge trigger_clk)
    begin
        if (reset || tlu_reset_flag)
            timestamp <= '0;
        else
            timestamp <= timestamp + 1'b1;
    end

    always_ff @(posedge trigger_clk)
    begin
        if (reset)
            trigger_counter <= '0;
        else if (trigger_counter_set)   // set wins over increment
            trigger_counter <= trigger_counter_set_value;
        else if (trigger_accepted_flag)
            trigger_counter <= trigger_counter + 1'b1;
    end

    // values closest to the trigger
    always_ff @(posedge trigger_clk)
    begin
        if (trigger_accepted_flag)
        begin
            timestamp_data <= timestamp;
            counter_data   <= trigger_counter;
        end
    end

    // TLU number only in number mode, internal count otherwise
    assign number_field = (trigger_mode == tlu_pkg::tlu_number)
                          ? {{(FIELD_W - `TLU_NUMBER_BITS){1'b0}}, tlu_number}
                          : counter_data[FIELD_W-1:0];

    always_comb
    begin
        case (conf_data_format)
            tlu_pkg::timestamp_only:
                trigger_data = {1'b1, timestamp_data[FIELD_W-1:0]};
            tlu_pkg::combined:
                trigger_data = {1'b1, timestamp_data[TS_W-1:0],
                                number_field[`TLU_NUMBER_BITS-1:0]};
            default:
                trigger_data = {1'b1, number_field};   // number_only and 2'b11
        endcase
    end

endmodule

// ==== design/tlu_handshake_fsm.sv ====
`timescale 1ns/1ps
`include "tlu_consts.svh"

module tlu_handshake_fsm
(
    input  logic                         trigger_clk,
    input  logic                         reset,
    input  logic                         trigger,
    input  logic                         trigger_veto,
    input  logic                         trigger_enable,
    input  tlu_pkg::trigger_mode_e       trigger_mode,
    input  logic [`TLU_TIMEOUT_BITS-1:0] low_timeout,
    input  logic                         trigger_acknowledge,
    input  logic                         fifo_acknowledge,
    input  logic                         number_done,
    output logic                         trigger_accepted_flag,
    output logic                         trigger_data_write,
    output logic                         fifo_preempt_req,
    output logic                         tlu_busy,
    output logic                         tlu_clock_enable,
    output logic                         low_timeout_error_flag
);

    typedef enum logic [2:0]
    {
        idle,
        send_command,
        wait_trigger_low,
        send_tlu_clock,
        latch_data,
        wait_ack
    } state_t;

    state_t state;
    state_t next;

    logic                         trigger_ff;
    logic                         trigger_flag;
    logic                         handshake_mode;
    logic                         number_mode;
    logic                         accept_trigger;
    logic                         trigger_ack_seen;
    logic                         fifo_ack_seen;
    logic                         both_acks;
    logic [`TLU_TIMEOUT_BITS-1:0] low_wait_cnt;
    logic                         timeout_hit;
    logic                         low_timeout_error;
    logic                         low_timeout_error_ff;
    logic                         busy;

    // rising edge of the external trigger
    always_ff @(posedge trigger_clk)
    begin
        if (reset)
            trigger_ff <= 1'b0;
        else
            trigger_ff <= trigger;
    end

    assign trigger_flag = trigger & ~trigger_ff;

    assign number_mode    = (trigger_mode == tlu_pkg::tlu_number);
    assign handshake_mode = (trigger_mode == tlu_pkg::tlu_handshake) || number_mode;

    // no new trigger while an acknowledge is still asserted
    assign accept_trigger = trigger_flag && trigger_enable && !trigger_veto
                            && !trigger_acknowledge && !fifo_acknowledge;

    // an acknowledge counts on the cycle it arrives
    assign both_acks = (trigger_ack_seen || trigger_acknowledge)
                       && (fifo_ack_seen || fifo_acknowledge);

    assign timeout_hit = (low_timeout != '0) && (low_wait_cnt >= low_timeout);

    always_comb
    begin
        next = state;
        case (state)
            idle:
            begin
                if (accept_trigger)
                    next = handshake_mode ? wait_trigger_low : send_command;
            end
            send_command:
                next = latch_data;   // simple mode, no handshake
            wait_trigger_low:
            begin
                if (!trigger || timeout_hit)
                    next = number_mode ? send_tlu_clock : latch_data;
            end
            send_tlu_clock:
            begin
                if (number_done)
                    next = latch_data;
            end
            latch_data:
                next = wait_ack;
            wait_ack:
            begin
                if (both_acks)
                    next = idle;
            end
            default:
                next = idle;
        endcase
    end

    always_ff @(posedge trigger_clk)
    begin
        if (reset)
            state <= idle;
        else
            state <= next;
    end

    // registered outputs, decoded from the next state
    always_ff @(posedge trigger_clk)
    begin
        if (reset)
        begin
            trigger_accepted_flag <= 1'b0;
            trigger_data_write    <= 1'b0;
            tlu_clock_enable      <= 1'b0;
            busy                  <= 1'b0;
        end
        else
        begin
            trigger_accepted_flag <= (state == idle) && (next != idle);
            trigger_data_write    <= (next == latch_data);
            tlu_clock_enable      <= (next == send_tlu_clock);
            busy                  <= (next != idle);
        end
    end

    assign tlu_busy         = busy;
    assign fifo_preempt_req = busy;

    // remember acknowledges from the accepted flag onward
    always_ff @(posedge trigger_clk)
    begin
        if (reset || state == idle)
        begin
            trigger_ack_seen <= 1'b0;
            fifo_ack_seen    <= 1'b0;
        end
        else
        begin
            if (trigger_acknowledge)
                trigger_ack_seen <= 1'b1;
            if (fifo_acknowledge)
                fifo_ack_seen <= 1'b1;
        end
    end

    // cycles spent waiting for trigger low, saturating
    always_ff @(posedge trigger_clk)
    begin
        if (reset || state != wait_trigger_low)
            low_wait_cnt <= '0;
        else if (low_wait_cnt != '1)
            low_wait_cnt <= low_wait_cnt + 1'b1;
    end

    always_ff @(posedge trigger_clk)
    begin
        if (reset)
        begin
            low_timeout_error    <= 1'b0;
            low_timeout_error_ff <= 1'b0;
        end
        else
        begin
            low_timeout_error    <= (state == wait_trigger_low) && trigger && timeout_hit;
            low_timeout_error_ff <= low_timeout_error;
        end
    end

    // one pulse per timeout
    assign low_timeout_error_flag = low_timeout_error & ~low_timeout_error_ff;

endmodule

// ==== design/tlu_number_deserializer.sv ====
`timescale 1ns/1ps
`include "tlu_consts.svh"

module tlu_number_deserializer
#(
    parameter int DIVISOR = `TLU_DIVISOR,
    parameter int PERIODS = `TLU_CLOCK_PERIODS
)
(
    input  logic                 trigger_clk,
    input  logic                 reset,
    input  logic                 tlu_clock_enable,
    input  logic                 trigger,
    input  logic                 msb_first,
    output logic                 tlu_clock,
    output logic                 number_done,
    output tlu_pkg::tlu_number_t tlu_number
);

    localparam int NB       = $bits(tlu_pkg::tlu_number_t);
    localparam int PHASE_W  = $clog2(DIVISOR);
    localparam int PERIOD_W = $clog2(PERIODS + 1);

    localparam logic [PHASE_W-1:0]  LAST_PHASE  = PHASE_W'(DIVISOR - 1);
    localparam logic [PHASE_W-1:0]  HALF_PHASE  = PHASE_W'(DIVISOR / 2);
    localparam logic [PERIOD_W-1:0] LAST_PERIOD = PERIOD_W'(PERIODS - 1);

    logic [PHASE_W-1:0]   phase_cnt;
    logic [PERIOD_W-1:0]  period_cnt;
    logic                 sample;
    tlu_pkg::tlu_number_t shift_reg;
    tlu_pkg::tlu_number_t shifted;
    tlu_pkg::tlu_number_t reversed;

    // high for the first half of each period
    assign tlu_clock = tlu_clock_enable && (phase_cnt < HALF_PHASE);

    // last cycle of a period, period 0 carries no data
    assign sample      = tlu_clock_enable && (phase_cnt == LAST_PHASE) && (period_cnt != '0);
    assign number_done = sample && (period_cnt == LAST_PERIOD);

    assign shifted = {shift_reg[NB-2:0], trigger};   // includes the bit sampled now

    always_comb
    begin
        for (int i = 0; i < NB; i++)
            reversed[i] = shifted[NB-1-i];
    end

    always_ff @(posedge trigger_clk)
    begin
        if (reset || !tlu_clock_enable)
        begin
            phase_cnt  <= '0;
            period_cnt <= '0;
            shift_reg  <= '0;
        end
        else
        begin
            if (phase_cnt == LAST_PHASE)
            begin
                phase_cnt  <= '0;
                period_cnt <= period_cnt + 1'b1;
            end
            else
                phase_cnt <= phase_cnt + 1'b1;
            if (sample)
                shift_reg <= shifted;
        end
    end

    // first received bit ends up as msb
    always_ff @(posedge trigger_clk)
    begin
        if (number_done)
            tlu_number <= msb_first ? shifted : reversed;
    end

endmodule

// ==== design/tlu_pkg.sv ====
`include "tlu_consts.svh"

package tlu_pkg;

    // 00 and 01 behave the same
    typedef enum logic [1:0]
    {
        simple        = 2'b00,
        simple_alt    = 2'b01,
        tlu_handshake = 2'b10,
        tlu_number    = 2'b11
    } trigger_mode_e;

    // 2'b11 falls back to number_only
    typedef enum logic [1:0]
    {
        number_only    = 2'b00,
        timestamp_only = 2'b01,
        combined       = 2'b10
    } data_format_e;

    typedef logic [`TLU_WORD_BITS-1:0] trigger_word_t;   // data word, timestamp, counter

    typedef logic [`TLU_NUMBER_BITS-1:0] tlu_number_t;   // deserialized TLU number

endpackage

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the TLU controller testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_tlu_controller -f sources.f \
    -Mdir "$BUILD_DIR" -o tb_sim
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

"./$BUILD_DIR/tb_sim" +verilator+error+limit+1000 > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "^TEST PASS$" "$LOG"; then
    exit 0
fi
exit 1

// ==== sources.f ====
+incdir+design
design/tlu_pkg.sv
design/tlu_handshake_fsm.sv
design/tlu_number_deserializer.sv
design/tlu_event_stamper.sv
design/tlu_controller_top.sv
testbench/tlu_controller_props.sv
testbench/tb_tlu_controller.sv

// ==== testbench/tb_tlu_controller.sv ====
`timescale 1ns/1ps
`include "tlu_consts.svh"

module tb_tlu_controller;

    localparam int NROWS       = 13;
    localparam int CLK_NS      = 100;
    localparam int WATCHDOG_NS = (NROWS + 1) * 400 * CLK_NS;   // reset check counts as a row

    typedef struct packed
    {
        tlu_pkg::trigger_mode_e mode;
        tlu_pkg::data_format_e  fmt;
        logic                   msb;
        tlu_pkg::tlu_number_t   number;
        logic [7:0]             high_cycles;
        logic [7:0]             timeout;
        logic [7:0]             ack_delay;
        logic                   extra_edge;   // second edge while waiting for fifo ack
        logic                   do_set;
        logic [31:0]            set_value;
    } row_t;

    logic clk;
    logic reset;
    logic trigger;
    logic trigger_veto;
    logic trigger_enable;
    logic trigger_acknowledge;
    logic fifo_acknowledge;
    logic trigger_counter_set;
    logic tlu_reset_flag;
    logic msb_first;
    logic [7:0] low_timeout;
    tlu_pkg::trigger_word_t trigger_counter_set_value;
    tlu_pkg::trigger_mode_e trigger_mode;
    tlu_pkg::data_format_e  conf_data_format;
    tlu_pkg::trigger_word_t trigger_data;
    tlu_pkg::trigger_word_t timestamp;
    logic trigger_data_write;
    logic trigger_accepted_flag;
    logic fifo_preempt_req;
    logic tlu_busy;
    logic tlu_clock;
    logic low_timeout_error_flag;

    row_t        rows [NROWS];
    string       names [NROWS];
    row_t        cur_row;
    string       cur_name;
    int          seed = 32'hf26c;
    int          cycle = 0;
    int          errors = 0;
    int          passed = 0;
    int          writes_seen = 0;
    int          accepts_seen = 0;
    int          timeouts_seen = 0;
    int          ts_ref;
    int          prev_ts_edge = -1;
    logic [31:0] prev_ts_word;
    logic [31:0] exp_count = '0;
    logic        write_found;
    logic [31:0] write_data;

    tlu_controller_top u_tlu_controller_top
    (
        .trigger_clk               (clk),
        .reset                     (reset),
        .trigger                   (trigger),
        .trigger_veto              (trigger_veto),
        .trigger_enable            (trigger_enable),
        .trigger_acknowledge       (trigger_acknowledge),
        .fifo_acknowledge          (fifo_acknowledge),
        .trigger_counter_set       (trigger_counter_set),
        .trigger_counter_set_value (trigger_counter_set_value),
        .trigger_mode              (trigger_mode),
        .conf_data_format          (conf_data_format),
        .low_timeout               (low_timeout),
        .msb_first                 (msb_first),
        .tlu_reset_flag            (tlu_reset_flag),
        .trigger_data              (trigger_data),
        .trigger_data_write        (trigger_data_write),
        .trigger_accepted_flag     (trigger_accepted_flag),
        .fifo_preempt_req          (fifo_preempt_req),
        .tlu_busy                  (tlu_busy),
        .tlu_clock                 (tlu_clock),
        .low_timeout_error_flag    (low_timeout_error_flag),
        .timestamp                 (timestamp)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    always @(posedge clk)
        cycle <= cycle + 1;

    always @(negedge clk)
    begin
        if (trigger_data_write)
            writes_seen++;
        if (trigger_accepted_flag)
            accepts_seen++;
        if (low_timeout_error_flag)
            timeouts_seen++;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("run timed out before all tests finished");
        $display("TEST FAIL");
        $finish;
    end

    function automatic row_t make_row(input tlu_pkg::trigger_mode_e mode,
                                      input tlu_pkg::data_format_e fmt, input logic msb,
                                      input int high, input int timeout, input int ack,
                                      input logic extra, input logic do_set,
                                      input logic [31:0] set_value);
        row_t r;
        r = '{mode, fmt, msb, '0, 8'(high), 8'(timeout), 8'(ack), extra, do_set, set_value};
        return r;
    endfunction

    // word layout: marker bit, then number, timestamp or both
    function automatic logic [31:0] expected_word(input row_t r, input logic [31:0] ts,
                                                  input logic [31:0] count);
        logic [30:0] num_field;
        num_field = (r.mode == tlu_pkg::tlu_number) ? 31'(r.number) : count[30:0];
        case (r.fmt)
            tlu_pkg::timestamp_only:
                return {1'b1, ts[30:0]};
            tlu_pkg::combined:
                return {1'b1, ts[14:0], num_field[15:0]};
            default:
                return {1'b1, num_field};
        endcase
    endfunction

    task automatic load_table();
        rows[0]  = make_row(tlu_pkg::simple, tlu_pkg::number_only, 0, 3, 0, 2, 0, 0, 0);
        rows[1]  = make_row(tlu_pkg::simple_alt, tlu_pkg::number_only, 0, 3, 0, 5, 0, 0, 0);
        rows[2]  = make_row(tlu_pkg::simple, tlu_pkg::number_only, 0, 3, 0, 2, 0, 1, 32'h1234);
        rows[3]  = make_row(tlu_pkg::simple, tlu_pkg::number_only, 0, 3, 0, 2, 0, 0, 0);
        rows[4]  = make_row(tlu_pkg::tlu_number, tlu_pkg::number_only, 1, 6, 0, 3, 0, 0, 0);
        rows[5]  = make_row(tlu_pkg::tlu_number, tlu_pkg::number_only, 0, 6, 0, 3, 0, 0, 0);
        rows[6]  = make_row(tlu_pkg::simple, tlu_pkg::timestamp_only, 0, 3, 0, 2, 0, 0, 0);
        rows[7]  = make_row(tlu_pkg::simple, tlu_pkg::timestamp_only, 0, 3, 0, 9, 0, 0, 0);
        rows[8]  = make_row(tlu_pkg::tlu_number, tlu_pkg::combined, 1, 4, 0, 2, 0, 0, 0);
        rows[9]  = make_row(tlu_pkg::tlu_handshake, tlu_pkg::number_only, 0, 12, 0, 2, 0, 0, 0);
        rows[10] = make_row(tlu_pkg::tlu_handshake, tlu_pkg::number_only, 0, 40, 10, 2, 0, 0, 0);
        rows[11] = make_row(tlu_pkg::simple, tlu_pkg::number_only, 0, 3, 0, 30, 1, 0, 0);
        rows[12] = make_row(tlu_pkg::simple, tlu_pkg::number_only, 0, 3, 0, 2, 0, 0, 0);
        names = '{"simple_count_0", "simple_count_1", "counter_set", "counter_after_set",
                  "number_msb_first", "number_lsb_first", "timestamp_first", "timestamp_second",
                  "combined_fields", "handshake_plain", "handshake_timeout", "backpressure",
                  "after_backpressure"};
        for (int i = 0; i < NROWS; i++)
            rows[i].number = tlu_pkg::tlu_number_t'($random(seed));
    endtask

    task automatic step_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] got);
        assert (got === exp)
        else
        begin
            $display("[FAIL] %s %s: expected %h actual %h", cur_name, what, exp, got);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string msg);
        assert (cond)
        else
        begin
            $display("error in %s: %s", cur_name, msg);
            errors++;
        end
    endtask

    // TLU side: bit k goes out after the k-th tlu_clock rise, bit 0 carries nothing
    task automatic send_tlu_number(input tlu_pkg::tlu_number_t number, input logic msb);
        for (int k = 0; k < `TLU_CLOCK_PERIODS; k++)
        begin
            @(posedge tlu_clock);
            #1;
            if (k == 0)
                trigger = 1'b0;
            else if (msb)
                trigger = number[`TLU_NUMBER_BITS - k];
            else
                trigger = number[k - 1];
        end
    endtask

    task automatic drive_trigger();
        trigger = 1'b1;
        repeat (cur_row.high_cycles) step_cycle();
        trigger = 1'b0;
        if (cur_row.mode == tlu_pkg::tlu_number)
            send_tlu_number(cur_row.number, cur_row.msb);
    endtask

    task automatic wait_write();
        write_found = 1'b0;
        write_data  = '0;
        for (int n = 0; n < 300 && !write_found; n++)
        begin
            @(negedge clk);
            if (trigger_data_write)
            begin
                write_found = 1'b1;
                write_data  = trigger_data;
            end
        end
    endtask

    task automatic run_row(input int i);
        int edge_cycle;
        int errors_before;
        int writes_before;
        int accepts_before;
        int timeouts_before;
        int busy_low;
        int exp_timeouts;
        cur_row = rows[i];
        cur_name = names[i];
        errors_before = errors;
        busy_low = 0;
        step_cycle();
        trigger_mode = cur_row.mode;
        conf_data_format = cur_row.fmt;
        msb_first = cur_row.msb;
        low_timeout = cur_row.timeout;
        if (cur_row.do_set)
        begin
            trigger_counter_set = 1'b1;
            trigger_counter_set_value = cur_row.set_value;
            exp_count = cur_row.set_value;
        end
        step_cycle();
        trigger_counter_set = 1'b0;
        repeat (3) step_cycle();
        check_value("timestamp", cycle - ts_ref - 1, timestamp);   // counts since the tlu reset
        writes_before = writes_seen;
        accepts_before = accepts_seen;
        timeouts_before = timeouts_seen;
        edge_cycle = cycle;   // trigger seen high in this cycle
        fork
            drive_trigger();
            wait_write();
        join
        check_true(write_found, "no data word was written");
        if (write_found)
            check_value("data word",
                        expected_word(cur_row, edge_cycle - ts_ref, exp_count), write_data);
        exp_count++;
        if (cur_row.fmt == tlu_pkg::timestamp_only)
        begin
            if (prev_ts_edge >= 0)
                check_value("timestamp step", edge_cycle - prev_ts_edge, write_data - prev_ts_word);
            prev_ts_edge = edge_cycle;
            prev_ts_word = write_data;
        end
        step_cycle();
        trigger = 1'b0;
        trigger_acknowledge = 1'b1;
        step_cycle();
        trigger_acknowledge = 1'b0;
        for (int n = 0; n < cur_row.ack_delay; n++)
        begin
            if (cur_row.extra_edge)
                trigger = (n >= cur_row.ack_delay / 2) && (n < cur_row.ack_delay / 2 + 2);
            @(negedge clk);
            if (!tlu_busy || !fifo_preempt_req)
                busy_low++;
            step_cycle();
        end
        fifo_acknowledge = 1'b1;
        step_cycle();
        fifo_acknowledge = 1'b0;
        @(negedge clk);
        check_true(busy_low == 0,
                   "tlu_busy or fifo_preempt_req dropped while fifo acknowledge was missing");
        check_true(!tlu_busy && !fifo_preempt_req,
                   "tlu_busy or fifo_preempt_req still high after both acknowledges");
        check_value("words written", writes_before + 1, writes_seen);
        check_value("accepted triggers", accepts_before + 1, accepts_seen);
        exp_timeouts = (cur_row.mode[1] && cur_row.timeout != 0
                        && cur_row.timeout + 2 <= cur_row.high_cycles) ? 1 : 0;
        check_value("timeout pulses", exp_timeouts, timeouts_seen - timeouts_before);
        if (errors == errors_before)
        begin
            passed++;
            $display("[PASS] %s", cur_name);
        end
        else
            $display("[DONE] %s with %0d failed checks", cur_name, errors - errors_before);
    endtask

    initial
    begin
        int prop_fail;
        reset = 1'b1;
        trigger = 1'b0;
        trigger_veto = 1'b0;
        trigger_enable = 1'b1;
        trigger_acknowledge = 1'b0;
        fifo_acknowledge = 1'b0;
        trigger_counter_set = 1'b0;
        trigger_counter_set_value = '0;
        trigger_mode = tlu_pkg::simple;
        conf_data_format = tlu_pkg::number_only;
        low_timeout = '0;
        msb_first = 1'b0;
        tlu_reset_flag = 1'b0;
        load_table();
        repeat (4) step_cycle();
        reset = 1'b0;
        cur_name = "reset";
        @(negedge clk);
        check_value("control outputs", '0, {trigger_data_write, trigger_accepted_flag, tlu_busy,
                                            fifo_preempt_req, tlu_clock, low_timeout_error_flag});
        if (errors == 0)
            passed++;
        $display("[%s] reset", errors == 0 ? "PASS" : "DONE");
        step_cycle();
        tlu_reset_flag = 1'b1;   // timestamp origin for expected values
        ts_ref = cycle;
        step_cycle();
        tlu_reset_flag = 1'b0;
        for (int i = 0; i < NROWS; i++)
            run_row(i);
        prop_fail = u_tlu_controller_top.u_tlu_handshake_fsm.u_tlu_controller_props.failures;
        $display("summary: %0d of %0d tests passed, %0d checks failed, %0d property failures",
                 passed, NROWS + 1, errors, prop_fail);
        if (errors == 0 && prop_fail == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

// ==== testbench/tlu_controller_props.sv ====
`timescale 1ns/1ps

module tlu_controller_props
(
    input logic                   trigger_clk,
    input logic                   reset,
    input tlu_pkg::trigger_mode_e trigger_mode,
    input logic                   trigger_data_write,
    input logic                   tlu_busy,
    input logic                   tlu_clock_enable
);

    int failures = 0;

    write_one_cycle: assert property (@(posedge trigger_clk) disable iff (reset)
        trigger_data_write |=> !trigger_data_write)
    else
    begin
        $error("trigger_data_write stayed high for more than one cycle");
        failures++;
    end

    // busy rises with the accepted flag, at least a cycle before the write
    write_while_busy: assert property (@(posedge trigger_clk) disable iff (reset)
        trigger_data_write |-> tlu_busy && $past(tlu_busy))
    else
    begin
        $error("trigger_data_write pulsed without tlu_busy high in this and the previous cycle");
        failures++;
    end

    // TLU clock only runs when the number is read out
    clock_only_number_mode: assert property (@(posedge trigger_clk) disable iff (reset)
        tlu_clock_enable |-> (trigger_mode == tlu_pkg::tlu_number))
    else
    begin
        $error("tlu_clock_enable high outside number mode");
        failures++;
    end

endmodule

bind tlu_handshake_fsm tlu_controller_props u_tlu_controller_props
(
    .trigger_clk        (trigger_clk),
    .reset              (reset),
    .trigger_mode       (trigger_mode),
    .trigger_data_write (trigger_data_write),
    .tlu_busy           (tlu_busy),
    .tlu_clock_enable   (tlu_clock_enable)
);
